/* rtl/rv32i_isa_pkg.sv */
package rv32i_isa_pkg;

	typedef enum logic [6:0] {
		OPCODE_LUI    = 7'b0110111,
		OPCODE_AUIPC  = 7'b0010111,
		OPCODE_JAL    = 7'b1101111,
		OPCODE_JALR   = 7'b1100111,
		OPCODE_BRANCH = 7'b1100011,
		OPCODE_LOAD   = 7'b0000011,
		OPCODE_STORE  = 7'b0100011,
		OPCODE_OP_IMM = 7'b0010011,
		OPCODE_OP     = 7'b0110011
	} opcode_t;

	localparam logic [2:0] FUNCT3_BRANCH_BEQ  = 3'b000;
	localparam logic [2:0] FUNCT3_BRANCH_BNE  = 3'b001;
	localparam logic [2:0] FUNCT3_BRANCH_BLT  = 3'b100;
	localparam logic [2:0] FUNCT3_BRANCH_BGE  = 3'b101;
	localparam logic [2:0] FUNCT3_BRANCH_BLTU = 3'b110;
	localparam logic [2:0] FUNCT3_BRANCH_BGEU = 3'b111;

	localparam logic [2:0] FUNCT3_LOAD_LB  = 3'b000;
	localparam logic [2:0] FUNCT3_LOAD_LH  = 3'b001;
	localparam logic [2:0] FUNCT3_LOAD_LW  = 3'b010;
	localparam logic [2:0] FUNCT3_LOAD_LBU = 3'b100;
	localparam logic [2:0] FUNCT3_LOAD_LHU = 3'b101;

	localparam logic [2:0] FUNCT3_STORE_SB = 3'b000;
	localparam logic [2:0] FUNCT3_STORE_SH = 3'b001;
	localparam logic [2:0] FUNCT3_STORE_SW = 3'b010;

	localparam logic [2:0] FUNCT3_OP_IMM_ADDI  = 3'b000;
	localparam logic [2:0] FUNCT3_OP_IMM_SLLI  = 3'b001;
	localparam logic [2:0] FUNCT3_OP_IMM_SLTI  = 3'b010;
	localparam logic [2:0] FUNCT3_OP_IMM_SLTIU = 3'b011;
	localparam logic [2:0] FUNCT3_OP_IMM_XORI  = 3'b100;
	localparam logic [2:0] FUNCT3_OP_IMM_SRI   = 3'b101; // SRLI or SRAI.
	localparam logic [2:0] FUNCT3_OP_IMM_ORI   = 3'b110;
	localparam logic [2:0] FUNCT3_OP_IMM_ANDI  = 3'b111;

	localparam logic [2:0] FUNCT3_OP_ADD_SUB = 3'b000;
	localparam logic [2:0] FUNCT3_OP_SLL     = 3'b001;
	localparam logic [2:0] FUNCT3_OP_SLT     = 3'b010;
	localparam logic [2:0] FUNCT3_OP_SLTU    = 3'b011;
	localparam logic [2:0] FUNCT3_OP_XOR     = 3'b100;
	localparam logic [2:0] FUNCT3_OP_SR      = 3'b101;
	localparam logic [2:0] FUNCT3_OP_OR      = 3'b110;
	localparam logic [2:0] FUNCT3_OP_AND     = 3'b111;

	typedef struct packed {
		logic [24:0] payload;
		opcode_t opcode;
	} common_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2, rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_t opcode;
	} rtype_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_t opcode;
	} itype_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2, rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		opcode_t opcode;
	} stype_t;

	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2, rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		opcode_t opcode;
	} btype_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0] rd;
		opcode_t opcode;
	} utype_t;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		opcode_t opcode;
	} jtype_t;

	typedef union packed {
		common_t common;
		rtype_t rtype;
		itype_t itype;
		stype_t stype;
		btype_t btype;
		utype_t utype;
		jtype_t jtype;
	} instruction_t;

endpackage

/* rtl/core_ctrl_pkg.sv */
package core_ctrl_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;

	typedef enum logic [1:0] {
		NEXT_PC_SEL_PC_4,
		NEXT_PC_SEL_ALU_OUT,
		NEXT_PC_SEL_COMPARE_UNIT_OUT // Taken branch goes to ALU result.
	} next_pc_sel_t;

	typedef enum logic [2:0] {
		REGFILE_IN_SEL_ALU_OUT,
		REGFILE_IN_SEL_PC_4,
		REGFILE_IN_SEL_MEM_RD,
		REGFILE_IN_SEL_MEM_RD_SEXT8,
		REGFILE_IN_SEL_MEM_RD_SEXT16
	} regfile_in_sel_t;

	typedef enum logic {
		MEM_RD_ADDR_SEL_PC,
		MEM_RD_ADDR_SEL_ALU_OUT
	} mem_rd_addr_sel_t;

	typedef enum logic {
		ALU_IN1_SEL_REGFILE_OUT1,
		ALU_IN1_SEL_PC
	} alu_in1_sel_t;

	typedef enum logic [2:0] {
		ALU_IN2_SEL_REGFILE_OUT2,
		ALU_IN2_SEL_IR_ITYPE_IMM,
		ALU_IN2_SEL_IR_STYPE_IMM,
		ALU_IN2_SEL_IR_BTYPE_IMM,
		ALU_IN2_SEL_IR_UTYPE_IMM,
		ALU_IN2_SEL_IR_JTYPE_IMM
	} alu_in2_sel_t;

	typedef enum logic [1:0] {
		MEM_ACCESS_SIZE_BYTE,
		MEM_ACCESS_SIZE_HALF,
		MEM_ACCESS_SIZE_WORD
	} mem_access_size_t;

	typedef enum logic [3:0] {
		ALU_OP_ADD,
		ALU_OP_SUB,
		ALU_OP_SLL,
		ALU_OP_SLT,
		ALU_OP_SLTU,
		ALU_OP_XOR,
		ALU_OP_SRL,
		ALU_OP_SRA,
		ALU_OP_OR,
		ALU_OP_AND,
		ALU_OP_IN2_PASSTHROUGH
	} alu_op_t;

	typedef enum logic [2:0] {
		COMPARE_UNIT_OP_EQ,
		COMPARE_UNIT_OP_NE,
		COMPARE_UNIT_OP_LT,
		COMPARE_UNIT_OP_GE,
		COMPARE_UNIT_OP_LTU,
		COMPARE_UNIT_OP_GEU
	} compare_unit_op_t;

endpackage

/* rtl/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if import core_ctrl_pkg::*; ();
	logic pc_we;
	logic ir_we;
	logic regfile_we;
	next_pc_sel_t next_pc_sel;
	regfile_in_sel_t regfile_in_sel;
	mem_rd_addr_sel_t mem_rd_addr_sel;
	mem_access_size_t mem_rd_size;
	mem_access_size_t mem_wr_size;
	logic mem_wr_enable;
	alu_op_t alu_op;
	alu_in1_sel_t alu_in1_sel;
	alu_in2_sel_t alu_in2_sel;
	compare_unit_op_t compare_unit_op;

	modport control (
		output pc_we, ir_we, regfile_we,
		output next_pc_sel, regfile_in_sel, mem_rd_addr_sel,
		output mem_rd_size, mem_wr_size, mem_wr_enable,
		output alu_op, alu_in1_sel, alu_in2_sel, compare_unit_op
	);

	modport datapath (
		input pc_we, ir_we, regfile_we,
		input next_pc_sel, regfile_in_sel, mem_rd_addr_sel,
		input mem_rd_size, mem_wr_size, mem_wr_enable,
		input alu_op, alu_in1_sel, alu_in2_sel, compare_unit_op
	);
endinterface

/* rtl/regfile.sv */
`timescale 1ns/1ps

module regfile import core_ctrl_pkg::*; (
	input logic clk_i,
	input logic we_i,
	input reg_idx_t rs1_i,
	input reg_idx_t rs2_i,
	input reg_idx_t rd_i,
	input word_t rd_data_i,
	output word_t rs1_data_o,
	output word_t rs2_data_o
);
	word_t regs [1:31]; // No storage behind x0.

	always_ff @(posedge clk_i) begin
		if (we_i && rd_i != 5'd0)
			regs[rd_i] <= rd_data_i;
	end

	assign rs1_data_o = (rs1_i == 5'd0) ? 32'h0000_0000 : regs[rs1_i];
	assign rs2_data_o = (rs2_i == 5'd0) ? 32'h0000_0000 : regs[rs2_i];
endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu import core_ctrl_pkg::*; (
	input alu_op_t op_i,
	input word_t in1_i,
	input word_t in2_i,
	output word_t result_o
);
	logic [4:0] shamt;

	assign shamt = in2_i[4:0];

	always_comb begin
		case (op_i)
			ALU_OP_ADD: result_o = in1_i + in2_i;
			ALU_OP_SUB: result_o = in1_i - in2_i;
			ALU_OP_SLL: result_o = in1_i << shamt;
			ALU_OP_SLT: result_o = {31'b0, $signed(in1_i) < $signed(in2_i)};
			ALU_OP_SLTU: result_o = {31'b0, in1_i < in2_i};
			ALU_OP_XOR: result_o = in1_i ^ in2_i;
			ALU_OP_SRL: result_o = in1_i >> shamt;
			ALU_OP_SRA: result_o = $signed(in1_i) >>> shamt;
			ALU_OP_OR: result_o = in1_i | in2_i;
			ALU_OP_AND: result_o = in1_i & in2_i;
			ALU_OP_IN2_PASSTHROUGH: result_o = in2_i; // LUI.
			default: result_o = 32'h0000_0000;
		endcase
	end
endmodule

/* rtl/control.sv */
`timescale 1ns/1ps

module control import rv32i_isa_pkg::*, core_ctrl_pkg::*; (
	input logic clk_i,
	input logic reset_i,
	input instruction_t ir_i,
	ctrl_if.control ctl
);
	typedef enum logic [1:0] {
		RESET,
		FETCH,
		DEMW
	} state_t;

	state_t state;

	// Sequencing strobes from the state alone.
	always_comb begin
		ctl.pc_we = 1'b0;
		ctl.ir_we = 1'b0;
		ctl.mem_rd_addr_sel = MEM_RD_ADDR_SEL_PC;
		case (state)
			FETCH: begin
				ctl.ir_we = 1'b1;
			end
			DEMW: begin
				ctl.pc_we = 1'b1; // Every instruction retires here.
				ctl.mem_rd_addr_sel = MEM_RD_ADDR_SEL_ALU_OUT;
			end
			default: ;
		endcase
	end

	// Decoder, active in DEMW only.
	always_comb begin
		ctl.regfile_we = 1'b0;
		ctl.next_pc_sel = NEXT_PC_SEL_PC_4;
		ctl.regfile_in_sel = REGFILE_IN_SEL_ALU_OUT;
		ctl.mem_rd_size = MEM_ACCESS_SIZE_WORD; // Instruction fetch.
		ctl.mem_wr_size = MEM_ACCESS_SIZE_WORD;
		ctl.mem_wr_enable = 1'b0;
		ctl.alu_op = ALU_OP_ADD;
		ctl.alu_in1_sel = ALU_IN1_SEL_REGFILE_OUT1;
		ctl.alu_in2_sel = ALU_IN2_SEL_REGFILE_OUT2;
		ctl.compare_unit_op = COMPARE_UNIT_OP_EQ;

		if (state == DEMW) begin
			case (ir_i.common.opcode)
				OPCODE_LUI: begin
					ctl.regfile_we = 1'b1;
					ctl.alu_op = ALU_OP_IN2_PASSTHROUGH;
					ctl.alu_in2_sel = ALU_IN2_SEL_IR_UTYPE_IMM;
				end
				OPCODE_AUIPC: begin
					ctl.regfile_we = 1'b1;
					ctl.alu_in1_sel = ALU_IN1_SEL_PC;
					ctl.alu_in2_sel = ALU_IN2_SEL_IR_UTYPE_IMM;
				end
				OPCODE_JAL: begin
					ctl.regfile_we = 1'b1;
					ctl.regfile_in_sel = REGFILE_IN_SEL_PC_4; // Link.
					ctl.next_pc_sel = NEXT_PC_SEL_ALU_OUT;
					ctl.alu_in1_sel = ALU_IN1_SEL_PC;
					ctl.alu_in2_sel = ALU_IN2_SEL_IR_JTYPE_IMM;
				end
				OPCODE_JALR: begin
					ctl.regfile_we = 1'b1;
					ctl.regfile_in_sel = REGFILE_IN_SEL_PC_4;
					ctl.next_pc_sel = NEXT_PC_SEL_ALU_OUT;
					ctl.alu_in2_sel = ALU_IN2_SEL_IR_ITYPE_IMM;
				end
				OPCODE_BRANCH: begin
					ctl.next_pc_sel = NEXT_PC_SEL_COMPARE_UNIT_OUT;
					ctl.alu_in1_sel = ALU_IN1_SEL_PC; // Target is PC + imm.
					ctl.alu_in2_sel = ALU_IN2_SEL_IR_BTYPE_IMM;
					case (ir_i.btype.funct3)
						FUNCT3_BRANCH_BNE:
							ctl.compare_unit_op = COMPARE_UNIT_OP_NE;
						FUNCT3_BRANCH_BLT:
							ctl.compare_unit_op = COMPARE_UNIT_OP_LT;
						FUNCT3_BRANCH_BGE:
							ctl.compare_unit_op = COMPARE_UNIT_OP_GE;
						FUNCT3_BRANCH_BLTU:
							ctl.compare_unit_op = COMPARE_UNIT_OP_LTU;
						FUNCT3_BRANCH_BGEU:
							ctl.compare_unit_op = COMPARE_UNIT_OP_GEU;
						default:
							ctl.compare_unit_op = COMPARE_UNIT_OP_EQ;
					endcase
				end
				OPCODE_LOAD: begin
					ctl.regfile_we = 1'b1;
					ctl.alu_in2_sel = ALU_IN2_SEL_IR_ITYPE_IMM;
					case (ir_i.itype.funct3)
						FUNCT3_LOAD_LB: begin
							ctl.mem_rd_size = MEM_ACCESS_SIZE_BYTE;
							ctl.regfile_in_sel = REGFILE_IN_SEL_MEM_RD_SEXT8;
						end
						FUNCT3_LOAD_LBU: begin
							ctl.mem_rd_size = MEM_ACCESS_SIZE_BYTE;
							ctl.regfile_in_sel = REGFILE_IN_SEL_MEM_RD;
						end
						FUNCT3_LOAD_LH: begin
							ctl.mem_rd_size = MEM_ACCESS_SIZE_HALF;
							ctl.regfile_in_sel = REGFILE_IN_SEL_MEM_RD_SEXT16;
						end
						FUNCT3_LOAD_LHU: begin
							ctl.mem_rd_size = MEM_ACCESS_SIZE_HALF;
							ctl.regfile_in_sel = REGFILE_IN_SEL_MEM_RD;
						end
						default: begin
							ctl.regfile_in_sel = REGFILE_IN_SEL_MEM_RD; // LW.
						end
					endcase
				end
				OPCODE_STORE: begin
					ctl.mem_wr_enable = 1'b1;
					ctl.alu_in2_sel = ALU_IN2_SEL_IR_STYPE_IMM;
					case (ir_i.stype.funct3)
						FUNCT3_STORE_SB:
							ctl.mem_wr_size = MEM_ACCESS_SIZE_BYTE;
						FUNCT3_STORE_SH:
							ctl.mem_wr_size = MEM_ACCESS_SIZE_HALF;
						default:
							ctl.mem_wr_size = MEM_ACCESS_SIZE_WORD;
					endcase
				end
				OPCODE_OP_IMM: begin
					ctl.regfile_we = 1'b1;
					ctl.alu_in2_sel = ALU_IN2_SEL_IR_ITYPE_IMM;
					case (ir_i.itype.funct3)
						FUNCT3_OP_IMM_SLTI:
							ctl.alu_op = ALU_OP_SLT;
						FUNCT3_OP_IMM_SLTIU:
							ctl.alu_op = ALU_OP_SLTU;
						FUNCT3_OP_IMM_XORI:
							ctl.alu_op = ALU_OP_XOR;
						FUNCT3_OP_IMM_ORI:
							ctl.alu_op = ALU_OP_OR;
						FUNCT3_OP_IMM_ANDI:
							ctl.alu_op = ALU_OP_AND;
						FUNCT3_OP_IMM_SLLI:
							ctl.alu_op = ALU_OP_SLL;
						FUNCT3_OP_IMM_SRI:
							ctl.alu_op = ir_i.rtype.funct7[5] ? ALU_OP_SRA : ALU_OP_SRL;
						default:
							ctl.alu_op = ALU_OP_ADD;
					endcase
				end
				OPCODE_OP: begin
					ctl.regfile_we = 1'b1;
					case (ir_i.rtype.funct3)
						FUNCT3_OP_ADD_SUB:
							ctl.alu_op = ir_i.rtype.funct7[5] ? ALU_OP_SUB : ALU_OP_ADD;
						FUNCT3_OP_SLL:
							ctl.alu_op = ALU_OP_SLL;
						FUNCT3_OP_SLT:
							ctl.alu_op = ALU_OP_SLT;
						FUNCT3_OP_SLTU:
							ctl.alu_op = ALU_OP_SLTU;
						FUNCT3_OP_XOR:
							ctl.alu_op = ALU_OP_XOR;
						FUNCT3_OP_SR:
							ctl.alu_op = ir_i.rtype.funct7[5] ? ALU_OP_SRA : ALU_OP_SRL;
						FUNCT3_OP_OR:
							ctl.alu_op = ALU_OP_OR;
						default:
							ctl.alu_op = ALU_OP_AND;
					endcase
				end
				default: ; // Unknown opcode falls through as a no-op.
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= RESET;
		end else begin
			case (state)
				FETCH: state <= DEMW;
				default: state <= FETCH;
			endcase
		end
	end
endmodule

/* rtl/datapath.sv */
`timescale 1ns/1ps

module datapath import rv32i_isa_pkg::*, core_ctrl_pkg::*; #(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input logic clk_i,
	input logic reset_i,
	ctrl_if.datapath ctl,
	output instruction_t ir_o,
	output word_t mem_addr_o,
	input word_t mem_rd_data_i,
	output word_t mem_wr_data_o
);
	word_t pc;
	word_t pc_4;
	word_t next_pc;
	instruction_t ir;
	word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	word_t rs1_data, rs2_data;
	word_t alu_in1, alu_in2, alu_result;
	word_t rd_data;
	logic branch_taken;

	always_ff @(posedge clk_i) begin
		if (reset_i)
			pc <= RESET_PC;
		else if (ctl.pc_we)
			pc <= next_pc;
	end

	always_ff @(posedge clk_i) begin
		if (ctl.ir_we)
			ir <= mem_rd_data_i;
	end

	assign ir_o = ir;
	assign pc_4 = pc + 32'd4;

	assign imm_i = {{20{ir.itype.imm[11]}}, ir.itype.imm};
	assign imm_s = {{20{ir.stype.imm_11_5[6]}}, ir.stype.imm_11_5, ir.stype.imm_4_0};
	assign imm_b = {{20{ir.btype.imm_12}}, ir.btype.imm_11, ir.btype.imm_10_5,
		ir.btype.imm_4_1, 1'b0};
	assign imm_u = {ir.utype.imm_31_12, 12'h000};
	assign imm_j = {{12{ir.jtype.imm_20}}, ir.jtype.imm_19_12, ir.jtype.imm_11,
		ir.jtype.imm_10_1, 1'b0};

	regfile u_regfile (
		.clk_i(clk_i),
		.we_i(ctl.regfile_we),
		.rs1_i(ir.rtype.rs1),
		.rs2_i(ir.rtype.rs2),
		.rd_i(ir.rtype.rd),
		.rd_data_i(rd_data),
		.rs1_data_o(rs1_data),
		.rs2_data_o(rs2_data)
	);

	assign alu_in1 = (ctl.alu_in1_sel == ALU_IN1_SEL_PC) ? pc : rs1_data;

	always_comb begin
		case (ctl.alu_in2_sel)
			ALU_IN2_SEL_IR_ITYPE_IMM: alu_in2 = imm_i;
			ALU_IN2_SEL_IR_STYPE_IMM: alu_in2 = imm_s;
			ALU_IN2_SEL_IR_BTYPE_IMM: alu_in2 = imm_b;
			ALU_IN2_SEL_IR_UTYPE_IMM: alu_in2 = imm_u;
			ALU_IN2_SEL_IR_JTYPE_IMM: alu_in2 = imm_j;
			default: alu_in2 = rs2_data;
		endcase
	end

	alu u_alu (
		.op_i(ctl.alu_op),
		.in1_i(alu_in1),
		.in2_i(alu_in2),
		.result_o(alu_result)
	);

	always_comb begin
		case (ctl.regfile_in_sel)
			REGFILE_IN_SEL_PC_4: rd_data = pc_4;
			REGFILE_IN_SEL_MEM_RD: rd_data = mem_rd_data_i;
			REGFILE_IN_SEL_MEM_RD_SEXT8: rd_data = {{24{mem_rd_data_i[7]}}, mem_rd_data_i[7:0]};
			REGFILE_IN_SEL_MEM_RD_SEXT16:
				rd_data = {{16{mem_rd_data_i[15]}}, mem_rd_data_i[15:0]};
			default: rd_data = alu_result;
		endcase
	end

	always_comb begin
		case (ctl.compare_unit_op)
			COMPARE_UNIT_OP_NE: branch_taken = rs1_data != rs2_data;
			COMPARE_UNIT_OP_LT: branch_taken = $signed(rs1_data) < $signed(rs2_data);
			COMPARE_UNIT_OP_GE: branch_taken = $signed(rs1_data) >= $signed(rs2_data);
			COMPARE_UNIT_OP_LTU: branch_taken = rs1_data < rs2_data;
			COMPARE_UNIT_OP_GEU: branch_taken = rs1_data >= rs2_data;
			default: branch_taken = rs1_data == rs2_data;
		endcase
	end

	always_comb begin
		case (ctl.next_pc_sel)
			NEXT_PC_SEL_ALU_OUT: next_pc = {alu_result[31:1], 1'b0}; // JALR clears bit 0.
			NEXT_PC_SEL_COMPARE_UNIT_OUT: next_pc = branch_taken ? alu_result : pc_4;
			default: next_pc = pc_4;
		endcase
	end

	assign mem_addr_o = (ctl.mem_rd_addr_sel == MEM_RD_ADDR_SEL_PC) ? pc : alu_result;
	assign mem_wr_data_o = rs2_data;
endmodule

/* rtl/rv32i_core.sv */
`timescale 1ns/1ps

module rv32i_core import rv32i_isa_pkg::*, core_ctrl_pkg::*; #(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input logic clk_i,
	input logic reset_i,
	output word_t mem_addr_o,
	input word_t mem_rd_data_i,
	output mem_access_size_t mem_rd_size_o,
	output word_t mem_wr_data_o,
	output mem_access_size_t mem_wr_size_o,
	output logic mem_wr_enable_o
);
	instruction_t ir;

	ctrl_if ctl ();

	control u_control (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.ir_i(ir),
		.ctl(ctl.control)
	);

	datapath #(
		.RESET_PC(RESET_PC)
	) u_datapath (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.ctl(ctl.datapath),
		.ir_o(ir),
		.mem_addr_o(mem_addr_o),
		.mem_rd_data_i(mem_rd_data_i),
		.mem_wr_data_o(mem_wr_data_o)
	);

	assign mem_rd_size_o = ctl.mem_rd_size;
	assign mem_wr_size_o = ctl.mem_wr_size;
	assign mem_wr_enable_o = ctl.mem_wr_enable;
endmodule

/* tb/core_sva.sv */
`timescale 1ns/1ps

module core_sva import core_ctrl_pkg::*; #(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input logic clk_i,
	input logic reset_i,
	input logic ir_we_i,
	input logic pc_we_i,
	input word_t next_pc_i,
	input word_t mem_addr_i,
	input word_t mem_wr_data_i,
	input mem_access_size_t mem_wr_size_i,
	input logic mem_wr_en_i,
	input word_t exp_addr_i,
	input word_t exp_data_i,
	input mem_access_size_t exp_size_i,
	input int exp_count_i
);
	int error_count = 0;
	word_t lane_mask;

	assign lane_mask = (mem_wr_size_i == MEM_ACCESS_SIZE_BYTE) ? 32'hFF :
		(mem_wr_size_i == MEM_ACCESS_SIZE_HALF) ? 32'hFFFF : 32'hFFFF_FFFF;

	reset_quiet: assert property (@(posedge clk_i) reset_i || $past(reset_i) |-> !mem_wr_en_i)
		else begin error_count++; $error("Store strobe during reset or the RESET cycle"); end

	first_fetch: assert property (@(posedge clk_i)
		$past(reset_i, 2) && !$past(reset_i) |-> ir_we_i && mem_addr_i == RESET_PC)
		else begin error_count++; $error("First fetch missed the reset address"); end

	fetch_follows: assert property (@(posedge clk_i) disable iff (reset_i)
		ir_we_i && $past(pc_we_i) |-> mem_addr_i == $past(next_pc_i))
		else begin error_count++; $error("Fetch address differs from the selected PC"); end

	single_store: assert property (@(posedge clk_i) disable iff (reset_i)
		mem_wr_en_i |=> !mem_wr_en_i)
		else begin error_count++; $error("Store strobe high for two cycles"); end

	store_match: assert property (@(posedge clk_i) disable iff (reset_i)
		mem_wr_en_i |-> exp_count_i > 0 && mem_addr_i == exp_addr_i &&
			mem_wr_size_i == exp_size_i && (mem_wr_data_i & lane_mask) == exp_data_i)
		else begin error_count++; $error("Store differs from the expected one"); end

	last_store: assert property (@(posedge clk_i) disable iff (reset_i)
		mem_wr_en_i && mem_addr_i == 32'h3FC |-> exp_count_i == 1)
		else begin error_count++; $error("Final store came with stores still pending"); end
endmodule

/* tb/core_tb.sv */
`timescale 1ns/1ps

module core_tb import rv32i_isa_pkg::*, core_ctrl_pkg::*; ;
	logic clk_i;
	logic reset_i;
	word_t mem_addr_o;
	word_t mem_rd_data_i;
	mem_access_size_t mem_rd_size_o;
	word_t mem_wr_data_o;
	mem_access_size_t mem_wr_size_o;
	logic mem_wr_enable_o;

	logic [7:0] mem [0:1023];
	word_t xr [0:31]; // Register values predicted by the ISA rules.
	word_t lfsr;
	int asm_pc;
	int n_instr;
	int slot;
	bit built;
	bit done;
	word_t exp_addr_q[$];
	word_t exp_data_q[$];
	mem_access_size_t exp_size_q[$];
	word_t head_addr;
	word_t head_data;
	mem_access_size_t head_size;
	int exp_count;
	logic wr_pending;
	word_t wr_addr;
	word_t wr_data;
	mem_access_size_t wr_size;

	rv32i_core #(
		.RESET_PC(32'h0000_0000)
	) uut (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.mem_addr_o(mem_addr_o),
		.mem_rd_data_i(mem_rd_data_i),
		.mem_rd_size_o(mem_rd_size_o),
		.mem_wr_data_o(mem_wr_data_o),
		.mem_wr_size_o(mem_wr_size_o),
		.mem_wr_enable_o(mem_wr_enable_o)
	);

	bind rv32i_core core_sva #(
		.RESET_PC(32'h0000_0000)
	) sva (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.ir_we_i(ctl.ir_we),
		.pc_we_i(ctl.pc_we),
		.next_pc_i(u_datapath.next_pc),
		.mem_addr_i(mem_addr_o),
		.mem_wr_data_i(mem_wr_data_o),
		.mem_wr_size_i(mem_wr_size_o),
		.mem_wr_en_i(mem_wr_enable_o),
		.exp_addr_i(core_tb.head_addr),
		.exp_data_i(core_tb.head_data),
		.exp_size_i(core_tb.head_size),
		.exp_count_i(core_tb.exp_count)
	);

	function automatic word_t rand_bits(int n);
		word_t v;
		v = 32'h0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic word_t op_result(logic [2:0] f3, bit alt, word_t a, word_t b);
		case (f3)
			FUNCT3_OP_ADD_SUB: return alt ? a - b : a + b;
			FUNCT3_OP_SLL: return a << b[4:0];
			FUNCT3_OP_SLT: return {31'b0, $signed(a) < $signed(b)};
			FUNCT3_OP_SLTU: return {31'b0, a < b};
			FUNCT3_OP_XOR: return a ^ b;
			FUNCT3_OP_SR: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			FUNCT3_OP_OR: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic bit branch_taken(logic [2:0] f3, word_t a, word_t b);
		case (f3)
			FUNCT3_BRANCH_BEQ: return a == b;
			FUNCT3_BRANCH_BNE: return a != b;
			FUNCT3_BRANCH_BLT: return $signed(a) < $signed(b);
			FUNCT3_BRANCH_BGE: return $signed(a) >= $signed(b);
			FUNCT3_BRANCH_BLTU: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic word_t size_mask(mem_access_size_t s);
		return (s == MEM_ACCESS_SIZE_BYTE) ? 32'hFF : (s == MEM_ACCESS_SIZE_HALF) ? 32'hFFFF : '1;
	endfunction

	task automatic refresh_head();
		exp_count = exp_addr_q.size();
		head_addr = (exp_count > 0) ? exp_addr_q[0] : 32'h0;
		head_data = (exp_count > 0) ? exp_data_q[0] : 32'h0;
		head_size = (exp_count > 0) ? exp_size_q[0] : MEM_ACCESS_SIZE_WORD;
	endtask

	task automatic emit(instruction_t ins);
		{mem[asm_pc + 3], mem[asm_pc + 2], mem[asm_pc + 1], mem[asm_pc]} = ins;
		asm_pc += 4;
		n_instr++;
	endtask

	task automatic op_reg(bit alt, logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
		instruction_t ins;
		ins.rtype = '{{1'b0, alt, 5'b0}, rs2, rs1, f3, rd, OPCODE_OP};
		emit(ins);
		if (rd != 0) xr[rd] = op_result(f3, alt, xr[rs1], xr[rs2]);
	endtask

	task automatic op_imm(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
		instruction_t ins;
		ins.itype = '{imm, rs1, f3, rd, OPCODE_OP_IMM};
		emit(ins);
		if (rd != 0)
			xr[rd] = op_result(f3, f3 == FUNCT3_OP_IMM_SRI && imm[10], xr[rs1],
				{{20{imm[11]}}, imm});
	endtask

	task automatic load_const(reg_idx_t rd, word_t v);
		instruction_t ins;
		word_t hi;
		hi = (v + 32'h800) >> 12;
		ins.utype = '{hi[19:0], rd, OPCODE_LUI};
		emit(ins);
		xr[rd] = {hi[19:0], 12'h000};
		op_imm(FUNCT3_OP_IMM_ADDI, rd, rd, v[11:0]);
	endtask

	// A store that is skipped on the correct path pushes nothing.
	task automatic store_at(reg_idx_t rs, logic [2:0] f3, word_t addr, bit expected);
		instruction_t ins;
		mem_access_size_t s;
		s = mem_access_size_t'(f3[1:0]);
		ins.stype = '{addr[11:5], rs, 5'd0, f3, addr[4:0], OPCODE_STORE};
		emit(ins);
		if (expected) begin
			exp_addr_q.push_back(addr);
			exp_data_q.push_back(xr[rs] & size_mask(s));
			exp_size_q.push_back(s);
		end
	endtask

	task automatic check_reg(reg_idx_t rs);
		store_at(rs, FUNCT3_STORE_SW, slot, 1'b1);
		slot += 4;
	endtask

	task automatic load_into(logic [2:0] f3, reg_idx_t rd, int addr);
		instruction_t ins;
		word_t w;
		ins.itype = '{addr[11:0], 5'd0, f3, rd, OPCODE_LOAD};
		emit(ins);
		w = {mem[addr + 3], mem[addr + 2], mem[addr + 1], mem[addr]};
		case (f3)
			FUNCT3_LOAD_LB: xr[rd] = {{24{w[7]}}, w[7:0]};
			FUNCT3_LOAD_LH: xr[rd] = {{16{w[15]}}, w[15:0]};
			FUNCT3_LOAD_LBU: xr[rd] = {24'h0, w[7:0]};
			FUNCT3_LOAD_LHU: xr[rd] = {16'h0, w[15:0]};
			default: xr[rd] = w;
		endcase
		check_reg(rd);
	endtask

	task automatic branch_skip(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2);
		instruction_t ins;
		logic [12:0] off;
		off = 13'd8; // Skips the marker store.
		ins.btype = '{off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPCODE_BRANCH};
		emit(ins);
		store_at(5'd7, FUNCT3_STORE_SW, slot, !branch_taken(f3, xr[rs1], xr[rs2]));
		slot += 4;
	endtask

	task automatic jump(reg_idx_t rd, logic [20:0] off);
		instruction_t ins;
		ins.jtype = '{off[20], off[10:1], off[11], off[19:12], rd, OPCODE_JAL};
		if (rd != 0) xr[rd] = asm_pc + 4;
		emit(ins);
	endtask

	task automatic build_program();
		instruction_t ins;
		word_t v;
		int p;
		load_const(5'd1, rand_bits(32));
		v = rand_bits(32);
		load_const(5'd2, (v == xr[1]) ? v ^ 32'h1 : v);
		load_const(5'd7, rand_bits(32));
		for (int f = 0; f < 8; f++) begin
			op_reg(1'b0, 3'(f), 5'd3, 5'd1, 5'd2);
			check_reg(5'd3);
		end
		op_reg(1'b1, FUNCT3_OP_ADD_SUB, 5'd3, 5'd1, 5'd2);
		check_reg(5'd3);
		op_reg(1'b1, FUNCT3_OP_SR, 5'd3, 5'd1, 5'd2);
		check_reg(5'd3);
		foreach (xr[f]) begin
			if (f < 8 && f != 1 && f != 5) begin
				op_imm(3'(f), 5'd4, 5'd1, 12'(rand_bits(12)));
				check_reg(5'd4);
			end
		end
		op_imm(FUNCT3_OP_IMM_SLLI, 5'd4, 5'd1, {7'b0, 5'(rand_bits(5))});
		check_reg(5'd4);
		op_imm(FUNCT3_OP_IMM_SRI, 5'd4, 5'd1, {7'b0, 5'(rand_bits(5))});
		check_reg(5'd4);
		op_imm(FUNCT3_OP_IMM_SRI, 5'd4, 5'd1, {7'b0100000, 5'(rand_bits(5))});
		check_reg(5'd4);
		v = rand_bits(20);
		ins.utype = '{v[19:0], 5'd5, OPCODE_LUI};
		emit(ins);
		xr[5] = v << 12;
		check_reg(5'd5);
		ins.utype = '{v[19:0], 5'd6, OPCODE_AUIPC};
		xr[6] = (v << 12) + asm_pc;
		emit(ins);
		check_reg(5'd6);
		load_into(FUNCT3_LOAD_LB, 5'd11, 'h301);
		load_into(FUNCT3_LOAD_LBU, 5'd12, 'h301);
		load_into(FUNCT3_LOAD_LH, 5'd13, 'h302);
		load_into(FUNCT3_LOAD_LHU, 5'd14, 'h302);
		load_into(FUNCT3_LOAD_LW, 5'd15, 'h300);
		store_at(5'd1, FUNCT3_STORE_SB, slot + 1, 1'b1);
		store_at(5'd1, FUNCT3_STORE_SH, slot + 6, 1'b1);
		slot += 8;
		foreach (xr[f]) begin
			if (f < 8 && f != 2 && f != 3) begin
				branch_skip(3'(f), 5'd1, 5'd1);
				branch_skip(3'(f), 5'd1, 5'd2);
				branch_skip(3'(f), 5'd2, 5'd1);
			end
		end
		jump(5'd8, 21'd8);
		store_at(5'd0, FUNCT3_STORE_SW, slot, 1'b0);
		slot += 4;
		check_reg(5'd8);
		p = asm_pc;
		op_imm(FUNCT3_OP_IMM_ADDI, 5'd9, 5'd0, 12'(p + 13)); // Odd target whose bit 0 must drop.
		ins.itype = '{12'h000, 5'd9, 3'b000, 5'd10, OPCODE_JALR};
		xr[10] = p + 8;
		emit(ins);
		store_at(5'd0, FUNCT3_STORE_SW, slot, 1'b0);
		slot += 4;
		check_reg(5'd10);
		store_at(5'd7, FUNCT3_STORE_SW, 32'h3FC, 1'b1);
		jump(5'd0, 21'd0);
	endtask

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// Memory answers from the address held since the last rising edge.
	always @(negedge clk_i) begin
		int a;
		a = mem_addr_o[9:0];
		case (mem_rd_size_o)
			MEM_ACCESS_SIZE_BYTE: mem_rd_data_i <= {24'h0, mem[a]};
			MEM_ACCESS_SIZE_HALF: mem_rd_data_i <= {16'h0, mem[(a + 1) % 1024], mem[a]};
			default: mem_rd_data_i <= {mem[(a + 3) % 1024], mem[(a + 2) % 1024],
				mem[(a + 1) % 1024], mem[a]};
		endcase
		wr_pending <= mem_wr_enable_o && !reset_i;
		wr_addr <= mem_addr_o;
		wr_data <= mem_wr_data_o;
		wr_size <= mem_wr_size_o;
	end

	always @(posedge clk_i) begin
		if (wr_pending) begin
			for (int k = 0; k < (1 << int'(wr_size)); k++)
				mem[(wr_addr[9:0] + k) % 1024] = wr_data[8 * k +: 8];
			if (exp_addr_q.size() > 0) begin
				void'(exp_addr_q.pop_front());
				void'(exp_data_q.pop_front());
				void'(exp_size_q.pop_front());
			end
			refresh_head();
			if (wr_addr == 32'h3FC) done = 1'b1;
			wr_pending = 1'b0;
		end
	end

	always @(negedge clk_i) begin
		if (uut.sva.error_count != 0) begin
			$display("FAILED at %0d ns: a bound assertion on the core failed", $time);
			$display("Testbench failed");
			$fatal(1, "Stopping at the first error");
		end
	end

	initial begin
		wait (built);
		#(n_instr * 32);
		$display("Timeout: the final store never reached address 0x3FC");
		$display("Testbench failed");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		reset_i = 1'b1;
		mem_rd_data_i = 32'h0;
		wr_pending = 1'b0;
		lfsr = 32'd414;
		asm_pc = 0;
		n_instr = 0;
		slot = 'h200;
		foreach (xr[r]) xr[r] = 32'h0;
		for (int i = 0; i < 1024; i++) mem[i] = 8'(i ^ (i >> 8) ^ 'h5A);
		{mem['h303], mem['h302], mem['h301], mem['h300]} = 32'hC7A5_9E8F; // Bits 7 and 15 set.
		build_program();
		refresh_head();
		built = 1'b1;
		repeat (3) @(negedge clk_i);
		reset_i = 1'b0;
		wait (done);
		@(negedge clk_i);
		if (uut.sva.error_count == 0 && exp_count == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("FAILED at %0d ns: stores left unchecked at the end", $time);
			$display("Testbench failed");
			$fatal(1, "Expected stores missing");
		end
	end
endmodule

/* sources.f */
rtl/rv32i_isa_pkg.sv
rtl/core_ctrl_pkg.sv
rtl/ctrl_if.sv
rtl/regfile.sv
rtl/alu.sv
rtl/control.sv
rtl/datapath.sv
rtl/rv32i_core.sv
tb/core_sva.sv
tb/core_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f sources.f -o core_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi
out=$(./obj_dir/core_sim +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	exit 1
fi
if echo "$out" | grep -q "^Testbench passed$"; then
	exit 0
fi
exit 1
